// ==== src/cache_config.svh ====
// global cache geometry; tag width derives from the other widths and must stay above zero
`default_nettype none

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address width
`define CACHE_ADDR_WIDTH 16

// log2 of sets and of 4-byte words per line
`define CACHE_LG_SETS 4
`define CACHE_LG_WORDS 2

// address minus index minus line offset
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_LG_SETS - `CACHE_LG_WORDS - 2)

// cycles from an address command to its finish pulse
`define CACHE_DMA_LATENCY 3

`endif

`default_nettype wire

// ==== src/cache_pkg.sv ====
// types for the two-way cache; widths come from cache_config.svh, no data words are carried
`include "cache_config.svh"

`default_nettype none

package cache_pkg;

  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CACHE_TAG_WIDTH-1:0] tag_t;
  typedef logic [`CACHE_LG_SETS-1:0] index_t;

  typedef enum logic [2:0] {
    LD,
    ST,
    TAGFL,
    AFL,
    AFLINV,
    AINV
  } cache_op_e;

  // one command per engine phase
  typedef enum logic [1:0] {
    FILL_ADDR,
    EVICT_ADDR,
    EVICT_DATA,
    FILL_DATA
  } mem_kind_e;

  typedef struct packed {
    logic valid;
    cache_op_e op;
    addr_t addr;
  } cache_req_t;

  typedef struct packed {
    logic valid;
    cache_op_e op;
    logic hit;
    addr_t addr;
  } cache_resp_t;

  typedef struct packed {
    logic valid;
    mem_kind_e kind;
    addr_t addr;
  } mem_cmd_t;

  // dirty per way, mru names the last used way
  typedef struct packed {
    logic [1:0] dirty;
    logic mru;
  } status_t;

endpackage

`default_nettype wire

// ==== src/cache_tag_mem.sv ====
// two-way tag store; one read per request, forced writes land in the last read set only
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_tag_mem (
  input  logic              clock_i,
  input  logic              reset_i,
  input  logic              rd_en_i,
  input  cache_pkg::index_t rd_index_i,
  output cache_pkg::tag_t   tag0_o,
  output cache_pkg::tag_t   tag1_o,
  output logic              valid0_o,
  output logic              valid1_o,
  input  logic              force_we_i,
  input  logic              force_way_i,
  input  cache_pkg::tag_t   force_tag_i,
  input  logic              force_valid_i
);

  import cache_pkg::*;

  localparam int unsigned SETS = 1 << `CACHE_LG_SETS;

  tag_t tag0_mem [SETS];
  tag_t tag1_mem [SETS];
  logic [SETS-1:0] valid0_r;
  logic [SETS-1:0] valid1_r;
  index_t index_r;

  // tags need no reset, valid bits do
  always_ff @(posedge clock_i) begin
    if (rd_en_i) begin
      index_r <= rd_index_i;
      tag0_o <= tag0_mem[rd_index_i];
      tag1_o <= tag1_mem[rd_index_i];
    end else if (force_we_i) begin
      if (force_way_i) begin
        tag1_mem[index_r] <= force_tag_i;
        tag1_o <= force_tag_i;
      end else begin
        tag0_mem[index_r] <= force_tag_i;
        tag0_o <= force_tag_i;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      valid0_r <= '0;
      valid1_r <= '0;
      valid0_o <= 1'b0;
      valid1_o <= 1'b0;
    end else if (rd_en_i) begin
      valid0_o <= valid0_r[rd_index_i];
      valid1_o <= valid1_r[rd_index_i];
    end else if (force_we_i) begin
      // held outputs follow the write so the miss handler sees it
      if (force_way_i) begin
        valid1_r[index_r] <= force_valid_i;
        valid1_o <= force_valid_i;
      end else begin
        valid0_r[index_r] <= force_valid_i;
        valid0_o <= force_valid_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_status_mem.sv ====
// dirty and mru bits per set; hit update and wipe must not collide, status_o is a snapshot at re_i
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_status_mem (
  input  logic               clock_i,
  input  logic               reset_i,
  input  cache_pkg::index_t  index_i,
  input  logic               hit_upd_i,
  input  logic               hit_way_i,
  input  logic               hit_store_i,
  input  logic               re_i,
  output cache_pkg::status_t status_o,
  input  logic               wipe_i,
  input  logic               wipe_way_i
);

  import cache_pkg::*;

  localparam int unsigned SETS = 1 << `CACHE_LG_SETS;

  logic [SETS-1:0] dirty0_r;
  logic [SETS-1:0] dirty1_r;
  logic [SETS-1:0] mru_r;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      dirty0_r <= '0;
      dirty1_r <= '0;
      mru_r <= '0;
      status_o <= '0;
    end else begin
      if (re_i) begin
        status_o.dirty <= {dirty1_r[index_i], dirty0_r[index_i]};
        status_o.mru <= mru_r[index_i];
      end
      if (hit_upd_i) begin
        mru_r[index_i] <= hit_way_i;
        // stores only ever set dirty here
        if (hit_store_i && hit_way_i) begin
          dirty1_r[index_i] <= 1'b1;
        end else if (hit_store_i) begin
          dirty0_r[index_i] <= 1'b1;
        end
      end else if (wipe_i) begin
        mru_r[index_i] <= ~wipe_way_i;
        if (wipe_way_i) begin
          dirty1_r[index_i] <= 1'b0;
        end else begin
          dirty0_r[index_i] <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_miss.sv ====
// miss and flush sequencer; expects miss_i held through the whole miss and one op at a time
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_miss (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  logic                 v_i,
  input  logic                 miss_i,
  input  cache_pkg::cache_op_e op_i,
  input  cache_pkg::addr_t     addr_i,
  input  cache_pkg::tag_t      tag0_i,
  input  cache_pkg::tag_t      tag1_i,
  input  logic                 valid0_i,
  input  logic                 valid1_i,
  input  logic                 tag_hit1_i,
  input  cache_pkg::status_t   status_i,
  input  logic                 dma_finished_i,
  output logic                 send_fill_req_o,
  output logic                 send_evict_req_o,
  output logic                 fill_line_o,
  output logic                 evict_line_o,
  output cache_pkg::addr_t     pass_addr_o,
  output logic                 status_re_o,
  output logic                 wipe_o,
  output logic                 tag_we_force_o,
  output logic                 chosen_set_o,
  output logic                 final_recover_o
);

  import cache_pkg::*;

  localparam int unsigned OFFSET_W = `CACHE_LG_WORDS + 2;

  typedef enum logic [2:0] {
    START,
    FLUSH_INSTR,
    FILL_REQUEST_SEND_ADDR,
    EVICT_REQUEST_SEND_ADDR,
    EVICT_REQUEST_SEND_DATA,
    FILL_REQUEST_GET_DATA,
    FINAL_RECOVER
  } miss_state_e;

  miss_state_e state_r;
  miss_state_e state_n;
  logic chosen_set_r;
  logic chosen_set_n;
  addr_t evict_addr_r;
  addr_t evict_addr_n;

  index_t index_w;
  logic tagfl_way_w;
  logic flush_op_w;
  logic fill_op_w;
  logic chosen_dirty_w;
  logic chosen_valid_w;

  assign index_w = addr_i[OFFSET_W +: `CACHE_LG_SETS];
  // lowest tag bit picks the way for a tag flush
  assign tagfl_way_w = addr_i[OFFSET_W + `CACHE_LG_SETS];
  assign flush_op_w = (op_i == TAGFL) || (op_i == AFL) || (op_i == AFLINV) || (op_i == AINV);
  assign fill_op_w = (op_i == LD) || (op_i == ST);

  assign chosen_dirty_w = chosen_set_n ? status_i.dirty[1] : status_i.dirty[0];
  assign chosen_valid_w = chosen_set_n ? valid1_i : valid0_i;

  // old line of the chosen way, taken before any forced tag write lands
  assign evict_addr_n = {(chosen_set_n ? tag1_i : tag0_i), index_w, {OFFSET_W{1'b0}}};

  assign chosen_set_o = chosen_set_n;

  always_comb begin
    state_n = state_r;
    chosen_set_n = chosen_set_r;
    send_fill_req_o = 1'b0;
    send_evict_req_o = 1'b0;
    fill_line_o = 1'b0;
    evict_line_o = 1'b0;
    pass_addr_o = addr_i;
    status_re_o = 1'b0;
    wipe_o = 1'b0;
    tag_we_force_o = 1'b0;
    final_recover_o = 1'b0;

    case (state_r)
      START: begin
        status_re_o = v_i && miss_i;
        if (v_i && miss_i && flush_op_w) begin
          state_n = FLUSH_INSTR;
        end else if (v_i && miss_i && fill_op_w) begin
          state_n = FILL_REQUEST_SEND_ADDR;
        end
      end

      FLUSH_INSTR: begin
        chosen_set_n = (op_i == TAGFL) ? tagfl_way_w : tag_hit1_i;
        tag_we_force_o = (op_i == AINV) || (op_i == AFLINV);
        wipe_o = 1'b1;
        if ((op_i != AINV) && chosen_dirty_w && chosen_valid_w) begin
          state_n = EVICT_REQUEST_SEND_ADDR;
        end else begin
          state_n = FINAL_RECOVER;
        end
      end

      // victim is the first invalid way, else the way that is not mru
      FILL_REQUEST_SEND_ADDR: begin
        chosen_set_n = valid0_i ? (valid1_i ? ~status_i.mru : 1'b1) : 1'b0;
        send_fill_req_o = 1'b1;
        tag_we_force_o = dma_finished_i;
        wipe_o = dma_finished_i;
        if (dma_finished_i && valid0_i && valid1_i && chosen_dirty_w) begin
          state_n = EVICT_REQUEST_SEND_ADDR;
        end else if (dma_finished_i) begin
          state_n = FILL_REQUEST_GET_DATA;
        end
      end

      EVICT_REQUEST_SEND_ADDR: begin
        send_evict_req_o = 1'b1;
        pass_addr_o = evict_addr_r;
        if (dma_finished_i) begin
          state_n = EVICT_REQUEST_SEND_DATA;
        end
      end

      EVICT_REQUEST_SEND_DATA: begin
        evict_line_o = 1'b1;
        pass_addr_o = evict_addr_r;
        if (dma_finished_i) begin
          state_n = flush_op_w ? FINAL_RECOVER : FILL_REQUEST_GET_DATA;
        end
      end

      FILL_REQUEST_GET_DATA: begin
        fill_line_o = 1'b1;
        if (dma_finished_i) begin
          state_n = FINAL_RECOVER;
        end
      end

      FINAL_RECOVER: begin
        final_recover_o = 1'b1;
        state_n = START;
      end

      default: begin
        state_n = START;
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= START;
      chosen_set_r <= 1'b0;
    end else begin
      state_r <= state_n;
      chosen_set_r <= chosen_set_n;
    end
  end

  // captured while the way is still being chosen
  always_ff @(posedge clock_i) begin
    if ((state_r == FLUSH_INSTR) || (state_r == FILL_REQUEST_SEND_ADDR)) begin
      evict_addr_r <= evict_addr_n;
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_dma.sv ====
// address-only line engine; strobes must be one-hot and held until finished, data time is counted
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_dma (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic                send_fill_req_i,
  input  logic                send_evict_req_i,
  input  logic                fill_line_i,
  input  logic                evict_line_i,
  input  cache_pkg::addr_t    pass_addr_i,
  output cache_pkg::mem_cmd_t mem_cmd_o,
  output logic                dma_finished_o
);

  import cache_pkg::*;

  localparam int unsigned LINE_CYCLES = 1 << `CACHE_LG_WORDS;
  localparam int unsigned MAX_CYCLES =
    (LINE_CYCLES > `CACHE_DMA_LATENCY) ? LINE_CYCLES : `CACHE_DMA_LATENCY;
  localparam int unsigned CNT_W = $clog2(MAX_CYCLES + 1);
  localparam int unsigned OFFSET_W = `CACHE_LG_WORDS + 2;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_BUSY,
    DMA_WAIT
  } dma_state_e;

  dma_state_e state_r;
  logic [3:0] phase_w;
  logic [3:0] phase_r;
  logic [CNT_W-1:0] cnt_r;
  logic [CNT_W-1:0] len_w;
  logic start_w;
  logic changed_w;
  mem_kind_e kind_w;

  assign phase_w = {fill_line_i, evict_line_i, send_evict_req_i, send_fill_req_i};
  assign changed_w = (phase_w != phase_r);
  // a new phase may start right out of the wait state
  assign start_w = (|phase_w) &&
                   ((state_r == DMA_IDLE) || ((state_r == DMA_WAIT) && changed_w));

  always_comb begin
    if (send_evict_req_i) begin
      kind_w = EVICT_ADDR;
    end else if (evict_line_i) begin
      kind_w = EVICT_DATA;
    end else if (fill_line_i) begin
      kind_w = FILL_DATA;
    end else begin
      kind_w = FILL_ADDR;
    end
  end

  // line phases use the line address and run one cycle per word
  assign len_w = (send_fill_req_i || send_evict_req_i) ? CNT_W'(`CACHE_DMA_LATENCY - 1)
                                                       : CNT_W'(LINE_CYCLES - 1);

  assign mem_cmd_o.valid = start_w;
  assign mem_cmd_o.kind = kind_w;
  assign mem_cmd_o.addr = (fill_line_i || evict_line_i)
                        ? {pass_addr_i[`CACHE_ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}}
                        : pass_addr_i;

  assign dma_finished_o = (state_r == DMA_BUSY) && (cnt_r == '0);

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r <= DMA_IDLE;
      phase_r <= '0;
      cnt_r <= '0;
    end else if (start_w) begin
      state_r <= DMA_BUSY;
      phase_r <= phase_w;
      cnt_r <= len_w;
    end else if (dma_finished_o) begin
      state_r <= DMA_WAIT;
    end else if (state_r == DMA_BUSY) begin
      cnt_r <= cnt_r - 1'b1;
    end else if ((state_r == DMA_WAIT) && changed_w) begin
      state_r <= DMA_IDLE;
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
// two-way cache controller; one request in flight, hits answer next cycle, no data path
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_top (
  input  logic                   clock_i,
  input  logic                   reset_i,
  input  cache_pkg::cache_req_t  req_i,
  output logic                   ready_o,
  output cache_pkg::cache_resp_t resp_o,
  output cache_pkg::mem_cmd_t    mem_cmd_o
);

  import cache_pkg::*;

  localparam int unsigned OFFSET_W = `CACHE_LG_WORDS + 2;

  cache_req_t stage_r;
  logic accept_w;
  logic miss_hold_r;
  logic miss_w;
  logic miss_now_w;
  logic hit0_w;
  logic hit1_w;
  logic fill_op_w;
  tag_t stage_tag_w;
  index_t stage_index_w;

  tag_t tag0;
  tag_t tag1;
  logic valid0;
  logic valid1;
  status_t status;
  logic send_fill_req;
  logic send_evict_req;
  logic fill_line;
  logic evict_line;
  addr_t pass_addr;
  logic status_re;
  logic wipe;
  logic tag_we_force;
  logic chosen_set;
  logic final_recover;
  logic dma_finished;

  assign stage_tag_w = stage_r.addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
  assign stage_index_w = stage_r.addr[OFFSET_W +: `CACHE_LG_SETS];
  assign fill_op_w = (stage_r.op == LD) || (stage_r.op == ST);

  assign hit0_w = valid0 && (tag0 == stage_tag_w);
  assign hit1_w = valid1 && (tag1 == stage_tag_w);

  // flush ops that miss have nothing to do and just respond
  always_comb begin
    if (fill_op_w) begin
      miss_now_w = !(hit0_w || hit1_w);
    end else if (stage_r.op == TAGFL) begin
      miss_now_w = 1'b1;
    end else begin
      miss_now_w = hit0_w || hit1_w;
    end
  end

  // forced tag writes change the hits, so the miss is held until recovery
  assign miss_w = miss_now_w || miss_hold_r;

  assign ready_o = !stage_r.valid || !miss_w || final_recover;
  assign accept_w = ready_o && req_i.valid;

  assign resp_o.valid = stage_r.valid && (!miss_w || final_recover);
  assign resp_o.op = stage_r.op;
  assign resp_o.hit = !miss_w && (hit0_w || hit1_w);
  assign resp_o.addr = stage_r.addr;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage_r.valid <= 1'b0;
      miss_hold_r <= 1'b0;
    end else begin
      if (ready_o) begin
        stage_r.valid <= req_i.valid;
      end
      if (final_recover) begin
        miss_hold_r <= 1'b0;
      end else if (stage_r.valid && miss_now_w) begin
        miss_hold_r <= 1'b1;
      end
    end
    if (accept_w) begin
      stage_r.op <= req_i.op;
      stage_r.addr <= req_i.addr;
    end
  end

  cache_tag_mem u_tag_mem (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .rd_en_i       (accept_w),
    .rd_index_i    (req_i.addr[OFFSET_W +: `CACHE_LG_SETS]),
    .tag0_o        (tag0),
    .tag1_o        (tag1),
    .valid0_o      (valid0),
    .valid1_o      (valid1),
    .force_we_i    (tag_we_force),
    .force_way_i   (chosen_set),
    .force_tag_i   (stage_tag_w),
    .force_valid_i (fill_op_w)
  );

  // hits and completed fills both mark mru, stores also mark dirty
  cache_status_mem u_status_mem (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .index_i     (stage_index_w),
    .hit_upd_i   (stage_r.valid && ((!miss_w && (hit0_w || hit1_w)) ||
                                    (final_recover && fill_op_w))),
    .hit_way_i   (final_recover ? chosen_set : hit1_w),
    .hit_store_i (stage_r.op == ST),
    .re_i        (status_re),
    .status_o    (status),
    .wipe_i      (wipe),
    .wipe_way_i  (chosen_set)
  );

  cache_miss u_miss (
    .clock_i          (clock_i),
    .reset_i          (reset_i),
    .v_i              (stage_r.valid),
    .miss_i           (miss_w),
    .op_i             (stage_r.op),
    .addr_i           (stage_r.addr),
    .tag0_i           (tag0),
    .tag1_i           (tag1),
    .valid0_i         (valid0),
    .valid1_i         (valid1),
    .tag_hit1_i       (hit1_w),
    .status_i         (status),
    .dma_finished_i   (dma_finished),
    .send_fill_req_o  (send_fill_req),
    .send_evict_req_o (send_evict_req),
    .fill_line_o      (fill_line),
    .evict_line_o     (evict_line),
    .pass_addr_o      (pass_addr),
    .status_re_o      (status_re),
    .wipe_o           (wipe),
    .tag_we_force_o   (tag_we_force),
    .chosen_set_o     (chosen_set),
    .final_recover_o  (final_recover)
  );

  cache_dma u_dma (
    .clock_i          (clock_i),
    .reset_i          (reset_i),
    .send_fill_req_i  (send_fill_req),
    .send_evict_req_i (send_evict_req),
    .fill_line_i      (fill_line),
    .evict_line_i     (evict_line),
    .pass_addr_i      (pass_addr),
    .mem_cmd_o        (mem_cmd_o),
    .dma_finished_o   (dma_finished)
  );

endmodule

`default_nettype wire

// ==== tb/cache_tb_check.svh ====
// included inside cache_tb after the cache_pkg import; model expects requests applied in table order
`ifndef CACHE_TB_CHECK_SVH
`define CACHE_TB_CHECK_SVH

// expected cache contents per set and way
tag_t m_tag [SETS][2];
logic m_valid [SETS][2];
logic m_dirty [SETS][2];
logic m_mru [SETS];

task automatic model_reset();
  int s;
  for (s = 0; s < SETS; s++) begin
    m_valid[s][0] = 1'b0;
    m_valid[s][1] = 1'b0;
    m_dirty[s][0] = 1'b0;
    m_dirty[s][1] = 1'b0;
    m_mru[s] = 1'b0;
    m_tag[s][0] = '0;
    m_tag[s][1] = '0;
  end
endtask

function automatic mem_cmd_t make_cmd(input mem_kind_e kind, input addr_t addr);
  mem_cmd_t c;
  c.valid = 1'b1;
  c.kind = kind;
  c.addr = addr;
  return c;
endfunction

task automatic push_cmd(input int r, input mem_cmd_t c);
  rows[r].cmds[rows[r].n_cmds] = c;
  rows[r].n_cmds = rows[r].n_cmds + 3'd1;
endtask

// fills in the expected hit bit and commands of one row, then updates the model
task automatic model_row(input int r);
  tag_t t;
  index_t idx;
  logic h0;
  logic h1;
  logic way;
  addr_t old_line;
  cache_op_e op;
  op = rows[r].op;
  t = rows[r].addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
  idx = rows[r].addr[OFFSET_W +: `CACHE_LG_SETS];
  h0 = m_valid[idx][0] && (m_tag[idx][0] == t);
  h1 = m_valid[idx][1] && (m_tag[idx][1] == t);
  rows[r].hit = 1'b0;
  rows[r].n_cmds = '0;
  rows[r].cmds = '0;
  if ((op == LD) || (op == ST)) begin
    if (h0 || h1) begin
      way = h1;
      rows[r].hit = 1'b1;
      m_mru[idx] = way;
      if (op == ST) m_dirty[idx][way] = 1'b1;
    end else begin
      // first invalid way, else the way that is not mru
      if (!m_valid[idx][0]) way = 1'b0;
      else if (!m_valid[idx][1]) way = 1'b1;
      else way = ~m_mru[idx];
      old_line = {m_tag[idx][way], idx, {OFFSET_W{1'b0}}};
      push_cmd(r, make_cmd(FILL_ADDR, rows[r].addr));
      if (m_valid[idx][0] && m_valid[idx][1] && m_dirty[idx][way]) begin
        push_cmd(r, make_cmd(EVICT_ADDR, old_line));
        push_cmd(r, make_cmd(EVICT_DATA, old_line));
      end
      push_cmd(r, make_cmd(FILL_DATA, {t, idx, {OFFSET_W{1'b0}}}));
      m_tag[idx][way] = t;
      m_valid[idx][way] = 1'b1;
      m_dirty[idx][way] = (op == ST);
      m_mru[idx] = way;
    end
  end else if ((op == TAGFL) || h0 || h1) begin
    // flushes answer with hit low once they go through the miss path
    way = (op == TAGFL) ? rows[r].addr[OFFSET_W + `CACHE_LG_SETS] : h1;
    old_line = {m_tag[idx][way], idx, {OFFSET_W{1'b0}}};
    if ((op != AINV) && m_valid[idx][way] && m_dirty[idx][way]) begin
      push_cmd(r, make_cmd(EVICT_ADDR, old_line));
      push_cmd(r, make_cmd(EVICT_DATA, old_line));
    end
    m_dirty[idx][way] = 1'b0;
    m_mru[idx] = ~way;
    if ((op == AINV) || (op == AFLINV)) m_valid[idx][way] = 1'b0;
  end
endtask

task automatic stop_on_error();
  error_count++;
  $display("Errors found");
  $fatal(1, "stopping at the first error");
endtask

task automatic check_resp(input string name, input cache_resp_t got, input cache_resp_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED time=%0t %s got=%h exp=%h", $time, name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_mem_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
  if (got !== exp) begin
    $display("CHECK FAILED time=%0t %s got=%h exp=%h", $time, name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    $display("CHECK FAILED time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("CHECK FAILED time=%0t %s got=%b exp=%b", $time, name, got, exp);
    stop_on_error();
  end
endtask

`endif

// ==== tb/cache_tb.sv ====
// directed plus seeded random table for cache_top; expects one request in flight at a time
`include "cache_config.svh"

`timescale 1ns/1ns
`default_nettype none

module cache_tb;

  import cache_pkg::*;

  localparam int SETS = 1 << `CACHE_LG_SETS;
  localparam int OFFSET_W = `CACHE_LG_WORDS + 2;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_ROWS = 48;
  localparam int ROW_CYCLES = 60;

  typedef struct packed {
    cache_op_e op;
    addr_t addr;
    logic hit;
    logic [2:0] n_cmds;
    mem_cmd_t [3:0] cmds;
  } row_t;

  logic clock_i;
  logic reset_i;
  cache_req_t req_i;
  logic ready_o;
  cache_resp_t resp_o;
  mem_cmd_t mem_cmd_o;

  row_t rows [MAX_ROWS];
  int n_rows;
  int error_count;
  logic [31:0] lfsr_q;

  `include "cache_tb_check.svh"

  cache_top u_dut (
    .clock_i   (clock_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .ready_o   (ready_o),
    .resp_o    (resp_o),
    .mem_cmd_o (mem_cmd_o)
  );

  initial begin
    clock_i = 1'b0;
    forever #(CLK_PERIOD / 2) clock_i = ~clock_i;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] r;
    logic b;
    int i;
    r = '0;
    for (i = 0; i < nbits; i++) begin
      b = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], b};
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic addr_t make_addr(input tag_t t, input index_t idx,
                                      input logic [OFFSET_W-1:0] off);
    return {t, idx, off};
  endfunction

  task automatic add_row(input cache_op_e op, input addr_t addr);
    rows[n_rows] = '0;
    rows[n_rows].op = op;
    rows[n_rows].addr = addr;
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    tag_t t;
    logic st;
    int k;
    n_rows = 0;
    // cold load then repeat
    add_row(LD, make_addr(8'h10, 4'd1, 4'h4));
    add_row(LD, make_addr(8'h10, 4'd1, 4'h4));
    // victim follows mru
    add_row(LD, make_addr(8'h20, 4'd2, 4'h0));
    add_row(LD, make_addr(8'h21, 4'd2, 4'h0));
    add_row(LD, make_addr(8'h20, 4'd2, 4'h8));
    add_row(LD, make_addr(8'h22, 4'd2, 4'h0));
    add_row(LD, make_addr(8'h21, 4'd2, 4'hc));
    // dirty eviction on conflict
    add_row(LD, make_addr(8'h30, 4'd3, 4'h0));
    add_row(LD, make_addr(8'h31, 4'd3, 4'h0));
    add_row(ST, make_addr(8'h30, 4'd3, 4'h4));
    add_row(LD, make_addr(8'h31, 4'd3, 4'h8));
    add_row(LD, make_addr(8'h32, 4'd3, 4'hc));
    // flush keeps the line, flush with invalidate drops it
    add_row(LD, make_addr(8'h40, 4'd4, 4'h0));
    add_row(ST, make_addr(8'h40, 4'd4, 4'h4));
    add_row(AFL, make_addr(8'h40, 4'd4, 4'h0));
    add_row(LD, make_addr(8'h40, 4'd4, 4'h8));
    add_row(ST, make_addr(8'h40, 4'd4, 4'h4));
    add_row(AFLINV, make_addr(8'h40, 4'd4, 4'h0));
    add_row(LD, make_addr(8'h40, 4'd4, 4'h0));
    // invalidate, and a flush that misses
    add_row(LD, make_addr(8'h50, 4'd5, 4'h0));
    add_row(AINV, make_addr(8'h50, 4'd5, 4'h0));
    add_row(LD, make_addr(8'h50, 4'd5, 4'h4));
    add_row(AFL, make_addr(8'h55, 4'd5, 4'h0));
    // tag flush by way with random tags
    for (k = 0; k < 6; k++) begin
      rnd = lfsr_take(`CACHE_TAG_WIDTH);
      t = rnd[`CACHE_TAG_WIDTH-1:0];
      rnd = lfsr_take(1);
      st = rnd[0];
      add_row(st ? ST : LD, make_addr(t, 4'd6, 4'h8));
      add_row(TAGFL, make_addr(t, 4'd6, 4'h0));
      add_row(TAGFL, make_addr(t ^ 8'h01, 4'd6, 4'h0));
    end
  endtask

  task automatic run_row(input int r);
    cache_resp_t exp_resp;
    int n_got;
    int n_cyc;
    logic done;
    @(posedge clock_i);
    #2;
    req_i.valid = 1'b1;
    req_i.op = rows[r].op;
    req_i.addr = rows[r].addr;
    @(negedge clock_i);
    // stage is empty between rows
    check_level("resp_o.valid", resp_o.valid, 1'b0);
    check_level("mem_cmd_o.valid", mem_cmd_o.valid, 1'b0);
    while (!ready_o) @(negedge clock_i);
    @(posedge clock_i);
    #2;
    req_i.valid = 1'b0;
    n_got = 0;
    n_cyc = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clock_i);
      n_cyc++;
      if (mem_cmd_o.valid) begin
        if (n_got >= int'(rows[r].n_cmds)) begin
          $display("row %0d: unexpected extra memory command %h at time %0t",
                   r, mem_cmd_o, $time);
          stop_on_error();
        end
        check_mem_cmd("mem_cmd_o", mem_cmd_o, rows[r].cmds[n_got]);
        n_got++;
      end
      if (resp_o.valid) done = 1'b1;
      // ready only in the cycle the stage finishes
      check_level("ready_o", ready_o, done);
    end
    exp_resp.valid = 1'b1;
    exp_resp.op = rows[r].op;
    exp_resp.hit = rows[r].hit;
    exp_resp.addr = rows[r].addr;
    check_resp("resp_o", resp_o, exp_resp);
    check_count("mem_cmd_o count", n_got, int'(rows[r].n_cmds));
    if (rows[r].hit) begin
      check_count("hit latency", n_cyc, 1);
    end
  endtask

  initial begin
    #((RESET_CYCLES + MAX_ROWS * ROW_CYCLES) * CLK_PERIOD);
    $display("watchdog timeout: DUT stopped responding at time %0t", $time);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int r;
    req_i = '0;
    reset_i = 1'b1;
    error_count = 0;
    lfsr_q = 32'hdc3d;
    model_reset();
    build_table();
    for (r = 0; r < n_rows; r++) model_row(r);
    repeat (RESET_CYCLES) @(posedge clock_i);
    #2;
    reset_i = 1'b0;
    for (r = 0; r < n_rows; r++) run_row(r);
    @(posedge clock_i);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
+incdir+tb
src/cache_pkg.sv
src/cache_tag_mem.sv
src/cache_status_mem.sv
src/cache_miss.sv
src/cache_dma.sv
src/cache_top.sv
tb/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module cache_tb -f filelist.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "No errors" "$LOG"; then
  echo "simulation ended without a pass line"
  exit 1
fi

exit 0
